/* sources.f */
+incdir+include
hw/acc_disp_pkg.sv
hw/acc_head_if.sv
hw/acc_insn_queue.sv
hw/acc_spec_tracker.sv
hw/acc_req_dispatch.sv
hw/mem_op_tracker.sv
hw/acc_hazard_ctrl.sv
hw/acc_dispatcher.sv
sim/tb_acc_dispatcher.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dispatcher testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module tb_acc_dispatcher -o tb_acc_dispatcher

./obj_dir/tb_acc_dispatcher > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

/* sim/tb_acc_dispatcher.sv */
/*
 * Accelerator dispatcher testbench with clock, reset, step table,
 * operand model queue, compare tasks and the final verdict
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

module tb_acc_dispatcher;
  import acc_disp_pkg::*;

  typedef logic [`ACC_TRANS_ID_W-1:0] id_t;
  typedef logic [`ACC_XLEN-1:0] word_t;

  // One table row with inputs first and expected outputs last
  typedef struct {
    logic    hs;
    fu_e     fu;
    acc_op_e op;
    id_t     id;
    logic [1:0] cv;
    id_t     cid0;
    id_t     cid1;
    logic    rdy;
    logic    flush;
    logic    cons;
    logic    bar;
    logic    spend;
    logic    ldc;
    logic    stc;
    logic    e_stall;
    logic    e_valid;
    id_t     e_id;
    logic    e_halt;
  } step_t;

  // Operands of an accepted ACCEL issue
  typedef struct {
    logic [`ACC_INSN_W-1:0] insn;
    word_t rs1;
    word_t rs2;
  } entry_t;

  logic clk_i;
  logic rst_i;
  logic flush_i;
  logic acc_cons_en_i;
  logic issue_hs_i;
  fu_e issue_fu_i;
  acc_op_e issue_op_i;
  id_t issue_trans_id_i;
  logic [`ACC_INSN_W-1:0] issue_insn_i;
  word_t issue_rs1_i;
  word_t issue_rs2_i;
  logic issue_stall_o;
  logic acc_valid_ex_o;
  logic [`ACC_NR_COMMIT_PORTS-1:0] commit_valid_i;
  fu_e [`ACC_NR_COMMIT_PORTS-1:0] commit_fu_i;
  logic [`ACC_NR_COMMIT_PORTS-1:0][`ACC_TRANS_ID_W-1:0] commit_trans_id_i;
  logic commit_st_barrier_i;
  logic acc_req_valid_o;
  logic acc_req_ready_i;
  logic [`ACC_INSN_W-1:0] acc_req_insn_o;
  word_t acc_req_rs1_o;
  word_t acc_req_rs2_o;
  id_t acc_req_trans_id_o;
  logic resp_valid_i;
  id_t resp_trans_id_i;
  word_t resp_result_i;
  logic resp_load_complete_i;
  logic resp_store_complete_i;
  logic resp_store_pending_i;
  logic acc_valid_o;
  id_t acc_trans_id_o;
  word_t acc_result_o;
  logic ctrl_halt_o;

  step_t steps[$];
  entry_t model[$];
  int cur_step;

  acc_dispatcher i_acc_dispatcher (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fail_value(input string msg);
    $display("ERR %0d ns: step %0d %s", $time, cur_step, msg);
    $display("TB FAILED");
    $fatal(1, "mismatch");
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) fail_value($sformatf("%s is %0b, expected %0b", what, got, exp));
  endtask

  task automatic check_trans_id(input id_t got, input id_t exp, input string what);
    if (got !== exp) fail_value($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) fail_value($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic add_step(input logic hs, input fu_e fu, input acc_op_e op, input id_t id,
                          input logic [1:0] cv, input id_t cid0, input id_t cid1,
                          input logic rdy, input logic flush, input logic cons,
                          input logic bar, input logic spend, input logic ldc,
                          input logic stc, input logic e_stall, input logic e_valid,
                          input id_t e_id, input logic e_halt);
    steps.push_back('{hs, fu, op, id, cv, cid0, cid1, rdy, flush, cons, bar, spend, ldc,
                      stc, e_stall, e_valid, e_id, e_halt});
  endtask

  // Request is combinational so a few ns suffice
  task automatic wait_request();
    int n;
    n = 0;
    while (!acc_req_valid_o && n < 5) begin
      #1;
      n++;
    end
    if (!acc_req_valid_o) begin
      $display("Timed out in step %0d waiting for an accelerator request", cur_step);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  endtask

  task automatic build_table();
    // Issue order and commit gating
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(1, FU_ACCEL, ACC_OP_ARITH, 1, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(1, FU_ACCEL, ACC_OP_ARITH, 2, 2'b11, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b10, 2, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b01, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 2, 0);
    // Back-pressure and queue full
    add_step(1, FU_ACCEL, ACC_OP_ARITH, 3, 2'b11, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b10, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 0);
    add_step(1, FU_ACCEL, ACC_OP_STORE, 4, 2'b11, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 0);
    add_step(1, FU_ACCEL, ACC_OP_LOAD,  5, 2'b11, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 0);
    add_step(0, FU_ACCEL, ACC_OP_ARITH, 0, 2'b11, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 3, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 3, 0);
    // Flush drops IDs 4 and 5 with their counts
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step(0, FU_LOAD,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 1, 1, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b10, 4, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_LOAD,  ACC_OP_ARITH, 0, 2'b10, 5, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(1, FU_ACCEL, ACC_OP_ARITH, 6, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b01, 0, 6, 1, 0, 0, 0, 0, 0, 0, 0, 1, 6, 0);
    // Memory consistency with a store and then a load in flight
    add_step(1, FU_ACCEL, ACC_OP_STORE, 7, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_LOAD,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step(0, FU_LOAD,  ACC_OP_ARITH, 0, 2'b10, 7, 0, 1, 0, 1, 0, 0, 0, 0, 1, 1, 7, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 1, 1, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_LOAD,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(1, FU_ACCEL, ACC_OP_LOAD,  0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_LOAD,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b10, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 1, 0, 1, 0, 0, 0);
    add_step(0, FU_STORE, ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    // Store barrier halt
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0);
    add_step(0, FU_NONE,  ACC_OP_ARITH, 0, 2'b11, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
  endtask

  initial begin
    step_t s;
    entry_t e;
    logic prev_push;

    void'($urandom(49651));
    rst_i = 1'b1;
    flush_i = 1'b0;
    acc_cons_en_i = 1'b0;
    issue_hs_i = 1'b0;
    issue_fu_i = FU_NONE;
    issue_op_i = ACC_OP_ARITH;
    issue_trans_id_i = '0;
    issue_insn_i = '0;
    issue_rs1_i = '0;
    issue_rs2_i = '0;
    commit_valid_i = '1;
    commit_fu_i[0] = FU_NONE;
    commit_fu_i[1] = FU_NONE;
    commit_trans_id_i = '0;
    commit_st_barrier_i = 1'b0;
    acc_req_ready_i = 1'b1;
    resp_valid_i = 1'b0;
    resp_trans_id_i = '0;
    resp_result_i = '0;
    resp_load_complete_i = 1'b0;
    resp_store_complete_i = 1'b0;
    resp_store_pending_i = 1'b0;
    prev_push = 1'b0;
    build_table();

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (cur_step = 0; cur_step < steps.size(); cur_step++) begin
      s = steps[cur_step];
      if (cur_step > 0) @(negedge clk_i);
      issue_hs_i = s.hs;
      issue_fu_i = s.fu;
      issue_op_i = s.op;
      issue_trans_id_i = s.id;
      issue_insn_i = $urandom;
      issue_rs1_i = $urandom;
      issue_rs2_i = $urandom;
      commit_valid_i = s.cv;
      commit_fu_i[0] = FU_ACCEL;
      commit_fu_i[1] = FU_ACCEL;
      commit_trans_id_i[0] = s.cid0;
      commit_trans_id_i[1] = s.cid1;
      acc_req_ready_i = s.rdy;
      flush_i = s.flush;
      acc_cons_en_i = s.cons;
      commit_st_barrier_i = s.bar;
      resp_store_pending_i = s.spend;
      resp_load_complete_i = s.ldc;
      resp_store_complete_i = s.stc;
      resp_valid_i = $urandom_range(0, 1);
      resp_trans_id_i = id_t'($urandom);
      resp_result_i = $urandom;

      // Accepted ACCEL issues enter the operand model
      if (s.hs && s.fu == FU_ACCEL && !s.e_stall && !s.flush) begin
        e.insn = issue_insn_i;
        e.rs1 = issue_rs1_i;
        e.rs2 = issue_rs2_i;
        model.push_back(e);
      end

      #10;
      if (s.e_valid) wait_request();
      check_level(issue_stall_o, s.e_stall, "issue_stall_o");
      check_level(acc_req_valid_o, s.e_valid, "acc_req_valid_o");
      check_level(ctrl_halt_o, s.e_halt, "ctrl_halt_o");
      check_level(acc_valid_ex_o, prev_push, "acc_valid_ex_o");
      check_level(acc_valid_o, resp_valid_i, "acc_valid_o");
      check_trans_id(acc_trans_id_o, resp_trans_id_i, "acc_trans_id_o");
      check_word(acc_result_o, resp_result_i, "acc_result_o");
      if (s.e_valid) begin
        if (model.size() == 0) fail_value("request seen with no issued entry left");
        check_trans_id(acc_req_trans_id_o, s.e_id, "acc_req_trans_id_o");
        check_word(acc_req_insn_o, model[0].insn, "acc_req_insn_o");
        check_word(acc_req_rs1_o, model[0].rs1, "acc_req_rs1_o");
        check_word(acc_req_rs2_o, model[0].rs2, "acc_req_rs2_o");
        if (s.rdy) void'(model.pop_front());
      end
      // Queued entries vanish on flush
      if (s.flush) model.delete();
      prev_push = s.hs && s.fu == FU_ACCEL && !s.e_stall && !s.flush;
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

/* hw/acc_dispatcher.sv */
/*
 * Accelerator dispatcher top level: queue, speculation tracker,
 * request register, memory-op trackers, hazard control, response path
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

module acc_dispatcher (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic                                                 flush_i,
  input  logic                                                 acc_cons_en_i,
  // Issue
  input  logic                                                 issue_hs_i,
  input  acc_disp_pkg::fu_e                                    issue_fu_i,
  input  acc_disp_pkg::acc_op_e                                issue_op_i,
  input  logic [`ACC_TRANS_ID_W-1:0]                           issue_trans_id_i,
  input  logic [`ACC_INSN_W-1:0]                               issue_insn_i,
  input  logic [`ACC_XLEN-1:0]                                 issue_rs1_i,
  input  logic [`ACC_XLEN-1:0]                                 issue_rs2_i,
  output logic                                                 issue_stall_o,
  output logic                                                 acc_valid_ex_o,
  // Commit
  input  logic [`ACC_NR_COMMIT_PORTS-1:0]                      commit_valid_i,
  input  acc_disp_pkg::fu_e [`ACC_NR_COMMIT_PORTS-1:0]         commit_fu_i,
  input  logic [`ACC_NR_COMMIT_PORTS-1:0][`ACC_TRANS_ID_W-1:0] commit_trans_id_i,
  input  logic                                                 commit_st_barrier_i,
  // Accelerator request
  output logic                                                 acc_req_valid_o,
  input  logic                                                 acc_req_ready_i,
  output logic [`ACC_INSN_W-1:0]                               acc_req_insn_o,
  output logic [`ACC_XLEN-1:0]                                 acc_req_rs1_o,
  output logic [`ACC_XLEN-1:0]                                 acc_req_rs2_o,
  output logic [`ACC_TRANS_ID_W-1:0]                           acc_req_trans_id_o,
  // Accelerator response
  input  logic                                                 resp_valid_i,
  input  logic [`ACC_TRANS_ID_W-1:0]                           resp_trans_id_i,
  input  logic [`ACC_XLEN-1:0]                                 resp_result_i,
  input  logic                                                 resp_load_complete_i,
  input  logic                                                 resp_store_complete_i,
  input  logic                                                 resp_store_pending_i,
  // Writeback and controller
  output logic                                                 acc_valid_o,
  output logic [`ACC_TRANS_ID_W-1:0]                           acc_trans_id_o,
  output logic [`ACC_XLEN-1:0]                                 acc_result_o,
  output logic                                                 ctrl_halt_o
);
  import acc_disp_pkg::*;

  acc_head_if head_if ();

  logic                    acc_ready;
  logic                    acc_push;
  logic [NR_MEM_KINDS-1:0] issue_strb;
  logic [NR_MEM_KINDS-1:0] disp_strb;
  logic [NR_MEM_KINDS-1:0] done_strb;
  logic [NR_MEM_KINDS-1:0] mem_idle;

  // Same acceptance as the queue push, marks the ID pending
  assign acc_push = issue_hs_i && (issue_fu_i == FU_ACCEL) && !issue_stall_o && !flush_i;

  acc_insn_queue i_acc_insn_queue (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .issue_hs_i       (issue_hs_i),
    .issue_fu_i       (issue_fu_i),
    .issue_op_i       (issue_op_i),
    .issue_trans_id_i (issue_trans_id_i),
    .issue_insn_i     (issue_insn_i),
    .issue_rs1_i      (issue_rs1_i),
    .issue_rs2_i      (issue_rs2_i),
    .head_o           (head_if.queue),
    .issue_strb_o     (issue_strb),
    .acc_ready_o      (acc_ready),
    .acc_valid_ex_o   (acc_valid_ex_o)
  );

  acc_spec_tracker i_acc_spec_tracker (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .flush_i               (flush_i),
    .push_i                (acc_push),
    .push_trans_id_i       (issue_trans_id_i),
    .commit_valid_i        (commit_valid_i),
    .commit_fu_i           (commit_fu_i),
    .commit_trans_id_i     (commit_trans_id_i),
    .head_i                (head_if.tracker),
    .dispatched_i          (acc_req_valid_o),
    .dispatched_trans_id_i (acc_req_trans_id_o)
  );

  acc_req_dispatch i_acc_req_dispatch (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .head_i             (head_if.dispatch),
    .acc_req_valid_o    (acc_req_valid_o),
    .acc_req_ready_i    (acc_req_ready_i),
    .acc_req_insn_o     (acc_req_insn_o),
    .acc_req_rs1_o      (acc_req_rs1_o),
    .acc_req_rs2_o      (acc_req_rs2_o),
    .acc_req_trans_id_o (acc_req_trans_id_o),
    .disp_strb_o        (disp_strb)
  );

  // Completions reported by the accelerator
  assign done_strb[MEM_LOAD]  = resp_load_complete_i;
  assign done_strb[MEM_STORE] = resp_store_complete_i;

  for (genvar k = 0; k < NR_MEM_KINDS; k++) begin : g_mem_trk
    mem_op_tracker i_mem_op_tracker (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .flush_i      (flush_i),
      .issue_strb_i (issue_strb[k]),
      .disp_strb_i  (disp_strb[k]),
      .done_strb_i  (done_strb[k]),
      .idle_o       (mem_idle[k])
    );
  end

  acc_hazard_ctrl i_acc_hazard_ctrl (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .issue_fu_i           (issue_fu_i),
    .acc_cons_en_i        (acc_cons_en_i),
    .acc_ready_i          (acc_ready),
    .mem_idle_i           (mem_idle),
    .commit_st_barrier_i  (commit_st_barrier_i),
    .resp_store_pending_i (resp_store_pending_i),
    .issue_stall_o        (issue_stall_o),
    .ctrl_halt_o          (ctrl_halt_o)
  );

  // Responses go straight to writeback
  assign acc_valid_o    = resp_valid_i;
  assign acc_trans_id_o = resp_trans_id_i;
  assign acc_result_o   = resp_result_i;

endmodule

/* hw/acc_hazard_ctrl.sv */
/*
 * Issue stall selection by functional unit and store-barrier halt
 */
`timescale 1ns/10ps

module acc_hazard_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  acc_disp_pkg::fu_e                     issue_fu_i,
  input  logic                                  acc_cons_en_i,
  input  logic                                  acc_ready_i,
  input  logic [acc_disp_pkg::NR_MEM_KINDS-1:0] mem_idle_i,
  input  logic                                  commit_st_barrier_i,
  input  logic                                  resp_store_pending_i,
  output logic                                  issue_stall_o,
  output logic                                  ctrl_halt_o
);
  import acc_disp_pkg::*;

  logic halt_q;

  always_comb begin
    case (issue_fu_i)
      // Queue has no room for another entry
      FU_ACCEL: issue_stall_o = !acc_ready_i;
      // Scalar load behind an accelerator store
      FU_LOAD:  issue_stall_o = acc_cons_en_i && !mem_idle_i[MEM_STORE];
      // Scalar store behind any accelerator memory op
      FU_STORE: issue_stall_o = acc_cons_en_i &&
                                (!mem_idle_i[MEM_STORE] || !mem_idle_i[MEM_LOAD]);
      default:  issue_stall_o = 1'b0;
    endcase
  end

  // Set by a store barrier, held while the accelerator has stores pending
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= (halt_q || commit_st_barrier_i) && resp_store_pending_i;
    end
  end

  assign ctrl_halt_o = halt_q;

endmodule

/* hw/mem_op_tracker.sv */
/*
 * Speculative and dispatched counters for one memory-op kind
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

module mem_op_tracker (
  input  logic clk_i,
  input  logic rst_i,
  input  logic flush_i,
  input  logic issue_strb_i,
  input  logic disp_strb_i,
  input  logic done_strb_i,
  output logic idle_o
);

  // Issued but still flushable
  logic [`ACC_MEM_CNT_W-1:0] spec_cnt_q;
  // Sent to the accelerator, waiting for completion
  logic [`ACC_MEM_CNT_W-1:0] disp_cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      spec_cnt_q <= '0;
    end else if (issue_strb_i && !disp_strb_i) begin
      spec_cnt_q <= spec_cnt_q + 1'b1;
    end else if (disp_strb_i && !issue_strb_i) begin
      spec_cnt_q <= spec_cnt_q - 1'b1;
    end
  end

  // Flush leaves dispatched ops alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      disp_cnt_q <= '0;
    end else if (disp_strb_i && !done_strb_i) begin
      disp_cnt_q <= disp_cnt_q + 1'b1;
    end else if (done_strb_i && !disp_strb_i) begin
      disp_cnt_q <= disp_cnt_q - 1'b1;
    end
  end

  assign idle_o = (spec_cnt_q == '0) && (disp_cnt_q == '0);

endmodule

/* hw/acc_req_dispatch.sv */
/*
 * Fall-through request register toward the accelerator,
 * queue pop and per-kind dispatch strobes
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

module acc_req_dispatch (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  acc_head_if.dispatch                          head_i,
  output logic                                  acc_req_valid_o,
  input  logic                                  acc_req_ready_i,
  output logic [`ACC_INSN_W-1:0]                acc_req_insn_o,
  output logic [`ACC_XLEN-1:0]                  acc_req_rs1_o,
  output logic [`ACC_XLEN-1:0]                  acc_req_rs2_o,
  output logic [`ACC_TRANS_ID_W-1:0]            acc_req_trans_id_o,
  output logic [acc_disp_pkg::NR_MEM_KINDS-1:0] disp_strb_o
);
  import acc_disp_pkg::*;

  logic                       in_valid;
  logic                       load;
  logic                       reg_valid_q;
  logic [`ACC_INSN_W-1:0]     insn_q;
  logic [`ACC_XLEN-1:0]       rs1_q;
  logic [`ACC_XLEN-1:0]       rs2_q;
  logic [`ACC_TRANS_ID_W-1:0] trans_id_q;

  // Head is offered only once non-speculative
  assign in_valid = head_i.head_valid && head_i.head_cleared;

  // Take the head when the register is empty or drains this cycle
  assign head_i.pop = in_valid && (!reg_valid_q || acc_req_ready_i);

  // Store the head unless it passes straight through
  assign load = head_i.pop && (reg_valid_q || !acc_req_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_valid_q <= 1'b0;
    end else if (load) begin
      reg_valid_q <= 1'b1;
    end else if (acc_req_ready_i) begin
      reg_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      insn_q     <= head_i.head_insn;
      rs1_q      <= head_i.head_rs1;
      rs2_q      <= head_i.head_rs2;
      trans_id_q <= head_i.head_trans_id;
    end
  end

  // Held entry has priority, otherwise fall through
  assign acc_req_valid_o    = reg_valid_q || in_valid;
  assign acc_req_insn_o     = reg_valid_q ? insn_q : head_i.head_insn;
  assign acc_req_rs1_o      = reg_valid_q ? rs1_q : head_i.head_rs1;
  assign acc_req_rs2_o      = reg_valid_q ? rs2_q : head_i.head_rs2;
  assign acc_req_trans_id_o = reg_valid_q ? trans_id_q : head_i.head_trans_id;

  // One strobe per popped load or store
  always_comb begin
    disp_strb_o            = '0;
    disp_strb_o[MEM_LOAD]  = head_i.pop && (head_i.head_op == ACC_OP_LOAD);
    disp_strb_o[MEM_STORE] = head_i.pop && (head_i.head_op == ACC_OP_STORE);
  end

endmodule

/* hw/acc_spec_tracker.sv */
/*
 * Speculation tracker: pending and ready bitmaps per transaction ID,
 * commit-port detection and the head-cleared flag
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

module acc_spec_tracker (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic                                               flush_i,
  input  logic                                               push_i,
  input  logic [`ACC_TRANS_ID_W-1:0]                         push_trans_id_i,
  input  logic [`ACC_NR_COMMIT_PORTS-1:0]                    commit_valid_i,
  input  acc_disp_pkg::fu_e [`ACC_NR_COMMIT_PORTS-1:0]       commit_fu_i,
  input  logic [`ACC_NR_COMMIT_PORTS-1:0][`ACC_TRANS_ID_W-1:0] commit_trans_id_i,
  acc_head_if.tracker                                        head_i,
  input  logic                                               dispatched_i,
  input  logic [`ACC_TRANS_ID_W-1:0]                         dispatched_trans_id_i
);
  import acc_disp_pkg::*;

  // Received by the dispatcher, still speculative
  logic [`ACC_NR_SB_ENTRIES-1:0] pending_q;
  logic [`ACC_NR_SB_ENTRIES-1:0] pending_d;
  // Reached the scoreboard head, not yet dispatched
  logic [`ACC_NR_SB_ENTRIES-1:0] ready_q;
  logic [`ACC_NR_SB_ENTRIES-1:0] ready_d;

  logic                       commit;
  logic [`ACC_TRANS_ID_W-1:0] commit_id;
  logic                       commit_hit;

  // First port whose result is not yet valid is the scoreboard head
  always_comb begin : commit_detect
    logic searching;
    searching = 1'b1;
    commit    = 1'b0;
    commit_id = commit_trans_id_i[0];
    for (int p = 0; p < `ACC_NR_COMMIT_PORTS; p++) begin
      if (searching && !commit_valid_i[p]) begin
        searching = 1'b0;
        commit    = commit_fu_i[p] == FU_ACCEL;
        commit_id = commit_trans_id_i[p];
      end
    end
  end

  // Only IDs the dispatcher actually holds count
  assign commit_hit = commit && pending_q[commit_id];

  always_comb begin : bitmap_next
    pending_d = pending_q;
    ready_d   = ready_q;
    if (push_i) begin
      pending_d[push_trans_id_i] = 1'b1;
    end
    if (flush_i) begin
      pending_d = '0;
    end
    // Move from pending to ready
    if (commit_hit) begin
      pending_d[commit_id] = 1'b0;
      ready_d[commit_id]   = 1'b1;
    end
    // Offered to the accelerator
    if (dispatched_i) begin
      ready_d[dispatched_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  // Cleared now or already ready, so the commit cycle can dispatch
  assign head_i.head_cleared = head_i.head_valid &&
                               (ready_q[head_i.head_trans_id] ||
                                (commit_hit && (commit_id == head_i.head_trans_id)));

endmodule

/* hw/acc_insn_queue.sv */
/*
 * Fall-through instruction queue for accelerator operands,
 * issue acceptance level and per-kind issue strobes
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

module acc_insn_queue (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  input  logic                                  issue_hs_i,
  input  acc_disp_pkg::fu_e                     issue_fu_i,
  input  acc_disp_pkg::acc_op_e                 issue_op_i,
  input  logic [`ACC_TRANS_ID_W-1:0]            issue_trans_id_i,
  input  logic [`ACC_INSN_W-1:0]                issue_insn_i,
  input  logic [`ACC_XLEN-1:0]                  issue_rs1_i,
  input  logic [`ACC_XLEN-1:0]                  issue_rs2_i,
  acc_head_if.queue                             head_o,
  output logic [acc_disp_pkg::NR_MEM_KINDS-1:0] issue_strb_o,
  output logic                                  acc_ready_o,
  output logic                                  acc_valid_ex_o
);
  import acc_disp_pkg::*;

  localparam int PTR_W = $clog2(`ACC_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`ACC_QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX    = PTR_W'(`ACC_QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] READY_LIMIT = CNT_W'(`ACC_QUEUE_DEPTH - 1);

  // Entry storage
  logic [`ACC_TRANS_ID_W-1:0] trans_id_mem [`ACC_QUEUE_DEPTH];
  logic [`ACC_INSN_W-1:0]     insn_mem     [`ACC_QUEUE_DEPTH];
  logic [`ACC_XLEN-1:0]       rs1_mem      [`ACC_QUEUE_DEPTH];
  logic [`ACC_XLEN-1:0]       rs2_mem      [`ACC_QUEUE_DEPTH];
  acc_op_e                    op_mem       [`ACC_QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] usage_q;
  logic             push;
  logic             pop;

  // Keep one slot spare, the entry in flight is counted late by the issue stage
  assign acc_ready_o = usage_q < READY_LIMIT;

  // Accepted ACCEL issue, dropped on flush
  assign push = issue_hs_i && (issue_fu_i == FU_ACCEL) && acc_ready_o && !flush_i;
  assign pop  = head_o.pop && (usage_q != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      // Usage moves only when one side acts alone
      if (push && !pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop && !push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push) begin
      trans_id_mem[wr_ptr_q] <= issue_trans_id_i;
      insn_mem[wr_ptr_q]     <= issue_insn_i;
      rs1_mem[wr_ptr_q]      <= issue_rs1_i;
      rs2_mem[wr_ptr_q]      <= issue_rs2_i;
      op_mem[wr_ptr_q]       <= issue_op_i;
    end
  end

  // Execute-stage pulse, one cycle after the handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_valid_ex_o <= 1'b0;
    end else begin
      acc_valid_ex_o <= push;
    end
  end

  // Head falls through from the read slot
  assign head_o.head_valid    = usage_q != '0;
  assign head_o.head_trans_id = trans_id_mem[rd_ptr_q];
  assign head_o.head_insn     = insn_mem[rd_ptr_q];
  assign head_o.head_rs1      = rs1_mem[rd_ptr_q];
  assign head_o.head_rs2      = rs2_mem[rd_ptr_q];
  assign head_o.head_op       = op_mem[rd_ptr_q];

  // Loads and stores accepted into the queue
  always_comb begin
    issue_strb_o            = '0;
    issue_strb_o[MEM_LOAD]  = push && (issue_op_i == ACC_OP_LOAD);
    issue_strb_o[MEM_STORE] = push && (issue_op_i == ACC_OP_STORE);
  end

endmodule

/* hw/acc_head_if.sv */
/*
 * Queue head bundle: head entry, pop request, non-speculative flag
 */
`timescale 1ns/10ps
`include "acc_disp_settings.svh"

interface acc_head_if;

  // Head entry, driven by the queue
  logic                        head_valid;
  logic [`ACC_TRANS_ID_W-1:0]  head_trans_id;
  logic [`ACC_INSN_W-1:0]      head_insn;
  logic [`ACC_XLEN-1:0]        head_rs1;
  logic [`ACC_XLEN-1:0]        head_rs2;
  acc_disp_pkg::acc_op_e       head_op;

  // Request stage takes the head
  logic                        pop;

  // Head ID reached the top of the scoreboard
  logic                        head_cleared;

  modport queue (
    output head_valid, head_trans_id, head_insn, head_rs1, head_rs2, head_op,
    input  pop
  );

  modport tracker (
    input  head_valid, head_trans_id,
    output head_cleared
  );

  modport dispatch (
    input  head_valid, head_trans_id, head_insn, head_rs1, head_rs2, head_op, head_cleared,
    output pop
  );

endinterface

/* hw/acc_disp_pkg.sv */
/*
 * Types shared by the dispatcher blocks:
 * functional units, accelerator opcode classes, memory-op kinds
 */
package acc_disp_pkg;

  // Functional unit of an issued or committing instruction
  typedef enum logic [1:0] {
    FU_NONE,
    FU_LOAD,
    FU_STORE,
    FU_ACCEL
  } fu_e;

  // Opcode class of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_ARITH,
    ACC_OP_LOAD,
    ACC_OP_STORE
  } acc_op_e;

  // Index into the per-kind strobe vectors
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_kind_e;

  // One tracker per memory kind
  localparam int NR_MEM_KINDS = 2;

endpackage

/* include/acc_disp_settings.svh */
/*
 * Widths, depths and counts for the accelerator dispatcher
 */
`ifndef ACC_DISP_SETTINGS_SVH
`define ACC_DISP_SETTINGS_SVH

// Scoreboard transaction IDs
`define ACC_TRANS_ID_W 3
`define ACC_NR_SB_ENTRIES 8
`define ACC_NR_COMMIT_PORTS 2

// Datapath
`define ACC_XLEN 32
`define ACC_INSN_W 32

// Buffering and memory-op counting
`define ACC_QUEUE_DEPTH 3
`define ACC_MEM_CNT_W 3

`endif
